//--- neuralLayer.f
+incdir+include
design/floatFormat_pkg.sv
design/layerBus_pkg.sv
design/fpMultiplier.sv
design/fpAdder.sv
design/neuronUnit.sv
design/layerRegisters.sv
design/neuralLayer.sv
bench/neuralLayer_tb.sv

//--- run.sh
#!/bin/sh
# compile the layer and its testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module neuralLayer_tb -f neuralLayer.f
./obj_dir/VneuralLayer_tb

//--- bench/neuralLayer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "layer_config.svh"

module neuralLayer_tb;

	localparam int clockPeriod = 4;
	localparam int rounds = 40;
	localparam int unmappedCount = 8;
	localparam int storageRegs = `LAYER_INPUTS + `LAYER_NEURONS * (`LAYER_INPUTS + 1);
	localparam int resultReads = `LAYER_NEURONS;
	localparam int plannedAccesses = resultReads + 2 * storageRegs + 2 * unmappedCount
		+ rounds * (storageRegs + resultReads) + resultReads + storageRegs + resultReads
		+ (`LAYER_INPUTS + `LAYER_NEURONS * `LAYER_INPUTS) * (1 + resultReads);
	localparam layerBus_pkg::wbAddr_t unmapped [unmappedCount] = '{8'h0A, 8'h0F, 8'h1B,
		8'h4F, 8'h50, 8'h7F, 8'h84, 8'hFF};

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	layerBus_pkg::wbAddr_t adr;
	layerBus_pkg::wbData_t datIn;
	layerBus_pkg::wbData_t datOut;
	logic ack;

	int seed;
	int clampCount;
	// operands as integers k, the float value is k/4
	int inK [`LAYER_INPUTS];
	int wK [`LAYER_NEURONS][`LAYER_INPUTS];
	int bK [`LAYER_NEURONS];
	layerBus_pkg::wbData_t shadow [0:255];
	layerBus_pkg::wbData_t readValue;

	neuralLayer neuralLayer_i
	(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	function automatic int randomK(input bit positiveOnly);
		int r;
		r = $random(seed);
		if (positiveOnly)
			return (r & 7) + 1;
		else
			return r % 9;
	endfunction

	// integer scaled by 16 to single precision, exact for small values
	function automatic floatFormat_pkg::float32_t toFloat(input int scaled);
		int mag;
		int msb;
		floatFormat_pkg::float32_t bits;
		bits = 32'd0;
		if (scaled != 0)
		begin
			mag = (scaled < 0) ? -scaled : scaled;
			msb = 0;
			for (int b = 0; b < 31; b++)
				if ((mag >> b) != 0)
					msb = b;
			bits[31] = scaled < 0;
			bits[30:23] = 8'(127 + msb - 4);
			bits[22:0] = 23'((mag << (23 - msb)) & 32'h007FFFFF);
		end
		return bits;
	endfunction

	// weighted sum plus bias, scale 16
	function automatic int neuronSum(input int n);
		int sum;
		sum = 4 * bK[n];
		for (int i = 0; i < `LAYER_INPUTS; i++)
			sum += inK[i] * wK[n][i];
		return sum;
	endfunction

	function automatic bit isStorage(input layerBus_pkg::wbAddr_t addr);
		bit inputSlot;
		bit neuronSlot;
		inputSlot = addr < `LAYER_INPUTS;
		neuronSlot = (addr >= 8'h10) && (addr < 8'(16 + 16 * `LAYER_NEURONS))
			&& (addr[3:0] <= 4'(`LAYER_INPUTS));
		return inputSlot || neuronSlot;
	endfunction

	// one classic cycle, stb stays up until ack has been seen at a rising edge
	task automatic busAccess(input logic writeEn, input layerBus_pkg::wbAddr_t addr,
		input layerBus_pkg::wbData_t data, output layerBus_pkg::wbData_t readBack);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = writeEn;
		adr = addr;
		datIn = data;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		readBack = datOut;
		@(posedge clk);
	endtask

	task automatic writeWord(input layerBus_pkg::wbAddr_t addr, input layerBus_pkg::wbData_t data);
		layerBus_pkg::wbData_t unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic readWord(input layerBus_pkg::wbAddr_t addr, output layerBus_pkg::wbData_t data);
		busAccess(1'b0, addr, 32'd0, data);
	endtask

	task automatic compareWord(input layerBus_pkg::wbAddr_t addr,
		input layerBus_pkg::wbData_t expected, input layerBus_pkg::wbData_t actual);
		assert (actual === expected)
		else
		begin
			$display("ERR datOut adr=%02h expected=%08h actual=%08h", addr, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "read mismatch");
		end
	endtask

	task automatic loadLayer(input bit positiveOnly);
		for (int i = 0; i < `LAYER_INPUTS; i++)
		begin
			inK[i] = randomK(positiveOnly);
			writeWord(8'(i), toFloat(4 * inK[i]));
		end
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			for (int i = 0; i < `LAYER_INPUTS; i++)
			begin
				wK[n][i] = randomK(positiveOnly);
				writeWord(8'(16 + 16 * n + i), toFloat(4 * wK[n][i]));
			end
			bK[n] = randomK(positiveOnly);
			writeWord(8'(16 + 16 * n + `LAYER_INPUTS), toFloat(4 * bK[n]));
		end
	endtask

	// first read follows a write directly, so it lands in settle
	task automatic checkResults();
		int sum;
		layerBus_pkg::wbData_t got;
		layerBus_pkg::wbData_t expected;
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			sum = neuronSum(n);
			expected = (sum > 0) ? toFloat(sum) : 32'd0;
			if (sum <= 0)
				clampCount++;
			readWord(8'(128 + n), got);
			compareWord(8'(128 + n), expected, got);
		end
	endtask

	initial
	begin
		repeat (plannedAccesses * 200 + 10) @(posedge clk);
		$display("watchdog expired, a bus access was never acknowledged in time");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		seed = 55430;
		clampCount = 0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			readWord(8'(128 + n), readValue);
			compareWord(8'(128 + n), 32'd0, readValue);
		end

		// raw words into storage, junk into holes in the map
		for (int a = 0; a < 128; a++)
		begin
			if (isStorage(8'(a)))
			begin
				shadow[a] = $random(seed);
				writeWord(8'(a), shadow[a]);
			end
		end
		for (int u = 0; u < unmappedCount; u++)
			writeWord(unmapped[u], $random(seed));
		for (int a = 0; a < 128; a++)
		begin
			if (isStorage(8'(a)))
			begin
				readWord(8'(a), readValue);
				compareWord(8'(a), shadow[a], readValue);
			end
		end
		for (int u = 0; u < unmappedCount; u++)
		begin
			readWord(unmapped[u], readValue);
			compareWord(unmapped[u], 32'd0, readValue);
		end

		for (int r = 0; r < rounds; r++)
		begin
			loadLayer(1'b0);
			// result registers are read only
			if (r == 0)
				for (int n = 0; n < `LAYER_NEURONS; n++)
					writeWord(8'(128 + n), $random(seed));
			checkResults();
		end
		assert (clampCount > 0)
		else
		begin
			$display("no round produced a negative or zero sum, so relu was never exercised");
			$display("TEST FAILED");
			$fatal(1, "relu unexercised");
		end

		// positive operands so every single change shows up in the sums
		loadLayer(1'b1);
		checkResults();
		for (int i = 0; i < `LAYER_INPUTS; i++)
		begin
			inK[i] = (inK[i] % 8) + 1;
			writeWord(8'(i), toFloat(4 * inK[i]));
			checkResults();
		end
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			for (int i = 0; i < `LAYER_INPUTS; i++)
			begin
				wK[n][i] = (wK[n][i] % 8) + 1;
				writeWord(8'(16 + 16 * n + i), toFloat(4 * wK[n][i]));
				checkResults();
			end
		end

		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		repeat (2) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/neuralLayer.sv
`timescale 1ns/1ps
`default_nettype none

`include "layer_config.svh"

module neuralLayer
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input layerBus_pkg::wbAddr_t adr,
	input layerBus_pkg::wbData_t datIn,
	output layerBus_pkg::wbData_t datOut,
	output logic ack
);

	floatFormat_pkg::float32_t [`LAYER_INPUTS-1:0] activations;
	floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0][`LAYER_INPUTS-1:0] weights;
	floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0] biases;
	floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0] results;

	layerRegisters registers_i
	(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.activations(activations),
		.weights(weights),
		.biases(biases),
		.results(results)
	);

	// every neuron sees the same activations
	for (genvar n = 0; n < `LAYER_NEURONS; n++)
	begin : neuron
		neuronUnit neuronUnit_i
		(
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.weights(weights[n]),
			.bias(biases[n]),
			.result(results[n])
		);
	end

endmodule

`default_nettype wire

//--- design/layerRegisters.sv
`timescale 1ns/1ps
`default_nettype none

`include "layer_config.svh"

module layerRegisters
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input layerBus_pkg::wbAddr_t adr,
	input layerBus_pkg::wbData_t datIn,
	output layerBus_pkg::wbData_t datOut,
	output logic ack,
	output floatFormat_pkg::float32_t [`LAYER_INPUTS-1:0] activations,
	output floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0][`LAYER_INPUTS-1:0] weights,
	output floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0] biases,
	input floatFormat_pkg::float32_t [`LAYER_NEURONS-1:0] results
);

	localparam int inputBits = $clog2(`LAYER_INPUTS);
	localparam int neuronBits = $clog2(`LAYER_NEURONS);
	localparam int settleBits = $clog2(`SETTLE_CYCLES + 1);

	layerBus_pkg::accessState_t state;
	logic [settleBits-1:0] settleCount;
	logic wasWrite;
	logic accept;
	logic isInput;
	logic isNeuron;
	logic isWeight;
	logic isBias;
	logic isResult;
	logic [inputBits-1:0] slotIdx;
	logic [neuronBits-1:0] neuronIdx;
	logic [neuronBits-1:0] resultIdx;
	layerBus_pkg::wbData_t readData;

	// address decode
	assign isInput = (adr[7:4] == 4'h0) && (adr[3:0] < `LAYER_INPUTS);
	assign isNeuron = !adr[7] && (adr[6:4] != 3'd0) && ({1'b0, adr[6:4]} <= `LAYER_NEURONS);
	assign isWeight = isNeuron && (adr[3:0] < `LAYER_INPUTS);
	assign isBias = isNeuron && (adr[3:0] == `LAYER_INPUTS);
	assign isResult = adr[7] && (adr[6:0] < `LAYER_NEURONS);
	assign slotIdx = inputBits'(adr[3:0]);
	assign neuronIdx = neuronBits'(adr[6:4] - 3'd1);
	assign resultIdx = neuronBits'(adr[6:0]);

	// requests wait out the settle window
	assign accept = cyc && stb && ((state == layerBus_pkg::idle)
		|| (state == layerBus_pkg::settle && settleCount == '0));
	assign ack = (state == layerBus_pkg::respond);

	always_comb
	begin
		readData = '0;
		if (isInput)
			readData = activations[slotIdx];
		else if (isWeight)
			readData = weights[neuronIdx][slotIdx];
		else if (isBias)
			readData = biases[neuronIdx];
		else if (isResult)
			readData = results[resultIdx];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activations <= '0;
			weights <= '0;
			biases <= '0;
		end
		else if (accept && we)
		begin
			if (isInput)
				activations[slotIdx] <= datIn;
			else if (isWeight)
				weights[neuronIdx][slotIdx] <= datIn;
			else if (isBias)
				biases[neuronIdx] <= datIn;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			datOut <= '0;
		else if (accept && !we)
			datOut <= readData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= layerBus_pkg::idle;
			settleCount <= '0;
			wasWrite <= 1'b0;
		end
		else
		begin
			case (state)
				layerBus_pkg::idle:
				begin
					if (accept)
					begin
						state <= layerBus_pkg::respond;
						wasWrite <= we;
					end
				end
				layerBus_pkg::settle:
				begin
					if (settleCount != '0)
						settleCount <= settleCount - 1'b1;
					else if (accept)
					begin
						state <= layerBus_pkg::respond;
						wasWrite <= we;
					end
					else
						state <= layerBus_pkg::idle;
				end
				layerBus_pkg::respond:
				begin
					// stb is still up here but is not a new request
					if (wasWrite)
					begin
						state <= layerBus_pkg::settle;
						settleCount <= settleBits'(`SETTLE_CYCLES - 1);
					end
					else
						state <= layerBus_pkg::idle;
				end
				default:
					state <= layerBus_pkg::idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held for two cycles");

	assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
		else $error("ack without an open bus cycle");

endmodule

`default_nettype wire

//--- design/neuronUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "layer_config.svh"

module neuronUnit
(
	input logic clk,
	input logic reset,
	input floatFormat_pkg::float32_t [`LAYER_INPUTS-1:0] activations,
	input floatFormat_pkg::float32_t [`LAYER_INPUTS-1:0] weights,
	input floatFormat_pkg::float32_t bias,
	output floatFormat_pkg::float32_t result
);

	floatFormat_pkg::float32_t [`LAYER_INPUTS-1:0] products;
	floatFormat_pkg::float32_t [`LAYER_INPUTS/2-1:0] pairSums;
	floatFormat_pkg::float32_t [1:0] quadSums;
	floatFormat_pkg::float32_t biasSum;
	floatFormat_pkg::float32_t octSum;
	floatFormat_pkg::float32_t total;

	for (genvar i = 0; i < `LAYER_INPUTS; i++)
	begin : mult
		fpMultiplier multiplier_i (.a(activations[i]), .b(weights[i]), .product(products[i]));
	end

	for (genvar p = 0; p < `LAYER_INPUTS/2; p++)
	begin : pairAdd
		fpAdder adder_i (.a(products[2*p]), .b(products[2*p+1]), .sum(pairSums[p]));
	end

	// tree order matters for rounding and stays fixed
	fpAdder quadAdder0_i (.a(pairSums[0]), .b(pairSums[1]), .sum(quadSums[0]));
	fpAdder quadAdder1_i (.a(pairSums[2]), .b(pairSums[3]), .sum(quadSums[1]));
	fpAdder biasAdder_i (.a(pairSums[4]), .b(bias), .sum(biasSum));
	fpAdder octAdder_i (.a(quadSums[0]), .b(quadSums[1]), .sum(octSum));
	fpAdder finalAdder_i (.a(octSum), .b(biasSum), .sum(total));

	// relu maps -0 to +0 as well
	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (total[31])
			result <= '0;
		else
			result <= total;
	end

	// the adder tree flushes tiny sums to zero
	assert property (@(posedge clk) disable iff (reset)
		(result[30:23] == 8'd0) |-> (result[22:0] == 23'd0))
		else $error("neuron result is subnormal");

endmodule

`default_nettype wire

//--- design/fpAdder.sv
`timescale 1ns/1ps
`default_nettype none

module fpAdder
(
	input floatFormat_pkg::float32_t a,
	input floatFormat_pkg::float32_t b,
	output floatFormat_pkg::float32_t sum
);

	logic swap;
	floatFormat_pkg::float32_t bigOp;
	floatFormat_pkg::float32_t smallOp;
	floatFormat_pkg::exponent_t bigExp;
	floatFormat_pkg::exponent_t smallExp;
	floatFormat_pkg::exponent_t expDiff;
	floatFormat_pkg::mantissa_t bigSig;
	floatFormat_pkg::mantissa_t smallSig;
	logic [49:0] shiftedSmall;
	logic [26:0] alignedBig;
	logic [26:0] alignedSmall;
	logic [27:0] rawSum;
	logic [26:0] normSum;
	logic [4:0] leadZeros;
	logic signed [9:0] normExp;
	logic signed [9:0] finalExp;
	logic roundUp;
	logic [24:0] rounded;
	logic [22:0] finalFrac;

	// order by magnitude so the difference never goes negative
	assign swap = b[30:0] > a[30:0];
	assign bigOp = swap ? b : a;
	assign smallOp = swap ? a : b;
	assign bigExp = bigOp[30:23];
	assign smallExp = smallOp[30:23];
	assign bigSig = (bigExp == 8'd0) ? 24'd0 : {1'b1, bigOp[22:0]};
	assign smallSig = (smallExp == 8'd0) ? 24'd0 : {1'b1, smallOp[22:0]};
	assign expDiff = bigExp - smallExp;

	// guard, round, then sticky collects everything shifted further out
	assign shiftedSmall = {smallSig, 26'd0} >> expDiff;
	assign alignedSmall = {shiftedSmall[49:24], |shiftedSmall[23:0]};
	assign alignedBig = {bigSig, 3'b000};

	assign rawSum = (a[31] == b[31]) ? {1'b0, alignedBig} + {1'b0, alignedSmall}
		: {1'b0, alignedBig} - {1'b0, alignedSmall};

	always_comb
	begin
		leadZeros = 5'd27;
		for (int i = 0; i < 27; i++)
			if (rawSum[i])
				leadZeros = 5'(26 - i);
	end

	always_comb
	begin
		if (rawSum[27])
		begin
			normSum = {rawSum[27:2], rawSum[1] | rawSum[0]};
			normExp = $signed({2'b00, bigExp}) + 10'sd1;
		end
		else
		begin
			normSum = rawSum[26:0] << leadZeros;
			normExp = $signed({2'b00, bigExp}) - $signed({5'd0, leadZeros});
		end
		roundUp = normSum[2] & (normSum[1] | normSum[0] | normSum[3]);
		rounded = {1'b0, normSum[26:3]} + {24'd0, roundUp};
		if (rounded[24])
		begin
			finalExp = normExp + 10'sd1;
			finalFrac = rounded[23:1];
		end
		else
		begin
			finalExp = normExp;
			finalFrac = rounded[22:0];
		end
		// exact cancellation gives +0
		if (rawSum == 28'd0)
			sum = 32'd0;
		else if (finalExp >= 10'sd255)
			sum = {bigOp[31], 8'hFF, 23'd0};
		else if (finalExp <= 10'sd0)
			sum = {bigOp[31], 31'd0};
		else
			sum = {bigOp[31], finalExp[7:0], finalFrac};
	end

endmodule

`default_nettype wire

//--- design/fpMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module fpMultiplier
(
	input floatFormat_pkg::float32_t a,
	input floatFormat_pkg::float32_t b,
	output floatFormat_pkg::float32_t product
);

	floatFormat_pkg::exponent_t expA;
	floatFormat_pkg::exponent_t expB;
	floatFormat_pkg::mantissa_t manA;
	floatFormat_pkg::mantissa_t manB;
	logic sign;
	logic [47:0] fullProduct;
	logic [22:0] fraction;
	logic guardBit;
	logic stickyBit;
	logic [24:0] rounded;
	logic signed [9:0] expSum;
	logic signed [9:0] expFinal;
	logic [22:0] fracFinal;

	assign expA = a[30:23];
	assign expB = b[30:23];
	assign manA = {1'b1, a[22:0]};
	assign manB = {1'b1, b[22:0]};
	assign sign = a[31] ^ b[31];
	assign fullProduct = 48'(manA) * 48'(manB);

	always_comb
	begin
		// product lies in [1,4) so at most one place of normalization
		if (fullProduct[47])
		begin
			fraction = fullProduct[46:24];
			guardBit = fullProduct[23];
			stickyBit = |fullProduct[22:0];
			expSum = $signed({2'b00, expA}) + $signed({2'b00, expB}) - 10'sd126;
		end
		else
		begin
			fraction = fullProduct[45:23];
			guardBit = fullProduct[22];
			stickyBit = |fullProduct[21:0];
			expSum = $signed({2'b00, expA}) + $signed({2'b00, expB}) - 10'sd127;
		end
		// nearest even
		rounded = {2'b01, fraction} + {24'd0, guardBit & (stickyBit | fraction[0])};
		if (rounded[24])
		begin
			expFinal = expSum + 10'sd1;
			fracFinal = rounded[23:1];
		end
		else
		begin
			expFinal = expSum;
			fracFinal = rounded[22:0];
		end
		// zero and subnormal operands count as zero
		if (expA == 8'd0 || expB == 8'd0)
			product = {sign, 31'd0};
		else if (expFinal >= 10'sd255)
			product = {sign, 8'hFF, 23'd0};
		else if (expFinal <= 10'sd0)
			product = {sign, 31'd0};
		else
			product = {sign, expFinal[7:0], fracFinal};
	end

endmodule

`default_nettype wire

//--- design/layerBus_pkg.sv
`default_nettype none

package layerBus_pkg;

	// word address on the wishbone port
	typedef logic [7:0] wbAddr_t;

	// data word on the wishbone port
	typedef logic [31:0] wbData_t;

	// slave access sequencing
	typedef enum logic [1:0]
	{
		idle,
		settle,
		respond
	} accessState_t;

endpackage

`default_nettype wire

//--- design/floatFormat_pkg.sv
`default_nettype none

package floatFormat_pkg;

	// ieee 754 single precision word
	typedef logic [31:0] float32_t;

	// biased exponent field
	typedef logic [7:0] exponent_t;

	// significand with the hidden bit in front
	typedef logic [23:0] mantissa_t;

endpackage

`default_nettype wire

//--- include/layer_config.svh
`ifndef LAYER_CONFIG_SVH
`define LAYER_CONFIG_SVH

// activations and weights per neuron
`define LAYER_INPUTS 10

// neurons side by side in the layer
`define LAYER_NEURONS 4

// clocks after a write until results are fresh
// one neuron output register
`define SETTLE_CYCLES 1

`endif
